//--- fetch_pkg.sv
// fetch package: shared types, framer states and packet constants for the sampling front end
`default_nettype none

package fetch_pkg;

	// ----------------------------------------------------------------------
	// data widths
	// ----------------------------------------------------------------------
	typedef logic [15:0] sample_t;
	typedef logic [15:0] word_t;
	typedef logic [15:0] len_t;
	typedef logic [19:0] period_t;
	typedef logic [15:0] frq_t;

	// device-count mode: 0 below 8, 1 for 8 to 15, 3 for 16 and up
	typedef logic [1:0] mode_t;

	// ----------------------------------------------------------------------
	// decoded configuration
	// ----------------------------------------------------------------------
	typedef struct packed {
		len_t    len_pkg;
		len_t    len_load;
		mode_t   mode;
		frq_t    tbit_frq;
		period_t tbit_period;
	} cfg_dec_t;

	// framer states
	typedef enum logic [2:0] {
		idle,
		head,
		load,
		check0,
		check1
	} frame_state_t;

	// ----------------------------------------------------------------------
	// packet layout
	// ----------------------------------------------------------------------
	localparam len_t  len_head  = 16'd12;
	localparam len_t  len_check = 16'd2;
	localparam word_t sync_word = 16'heb90;

	// mode codes
	localparam mode_t mode_small = 2'h0;
	localparam mode_t mode_mid   = 2'h1;
	localparam mode_t mode_large = 2'h3;

endpackage

`default_nettype wire

//--- fetch_base.sv
// configuration decoder mapping device count and rate code to packet length, mode and tick timing
`timescale 1ns/10ps
`default_nettype none

module fetch_base import fetch_pkg::*; #(
	parameter int samples_per_unit = 900
) (
	input  wire         clk_sys,
	input  wire         rst,
	input  wire  [7:0]  cfg_numdev,
	input  wire  [7:0]  cfg_sample,
	output cfg_dec_t    cfg_dec
);

	// defaults match rate code 20 with fewer than 8 devices
	localparam len_t load_dflt = len_t'(samples_per_unit * 20);

	len_t    units;
	len_t    load_next;
	frq_t    frq_next;
	period_t period_next;

	// ----------------------------------------------------------------------
	// payload size from rate code
	// ----------------------------------------------------------------------
	always_comb begin
		case (cfg_sample)
			8'd20:   units = 16'd20;
			8'd10:   units = 16'd10;
			8'd5:    units = 16'd5;
			8'd2:    units = 16'd2;
			8'd1:    units = 16'd1;
			default: units = 16'd20;
		endcase
		load_next = len_t'(samples_per_unit) * units;
	end

	// tick frequency from one table per mode
	// the table is picked by the registered mode
	always_comb begin
		case (cfg_dec.mode)
			mode_large: begin
				case (cfg_sample)
					8'd20:   frq_next = 16'd5000;
					8'd10:   frq_next = 16'd4000;
					8'd5:    frq_next = 16'd2000;
					8'd2:    frq_next = 16'd1000;
					8'd1:    frq_next = 16'd500;
					default: frq_next = 16'd5000;
				endcase
			end
			mode_mid: begin
				case (cfg_sample)
					8'd20:   frq_next = 16'd4000;
					8'd10:   frq_next = 16'd2000;
					8'd5:    frq_next = 16'd1000;
					8'd2:    frq_next = 16'd500;
					8'd1:    frq_next = 16'd200;
					default: frq_next = 16'd4000;
				endcase
			end
			default: begin
				case (cfg_sample)
					8'd20:   frq_next = 16'd2000;
					8'd10:   frq_next = 16'd1000;
					8'd5:    frq_next = 16'd500;
					8'd2:    frq_next = 16'd200;
					8'd1:    frq_next = 16'd200;
					default: frq_next = 16'd2000;
				endcase
			end
		endcase
	end

	// period is 100000 divided by frq
	// unknown codes fall back to 20
	always_comb begin
		case (frq_next)
			16'd5000: period_next = 20'd20;
			16'd4000: period_next = 20'd25;
			16'd2000: period_next = 20'd50;
			16'd1000: period_next = 20'd100;
			16'd500:  period_next = 20'd200;
			16'd200:  period_next = 20'd500;
			16'd100:  period_next = 20'd1000;
			default:  period_next = 20'd20;
		endcase
	end

	// ----------------------------------------------------------------------
	// registered outputs
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg_dec.len_load    <= load_dflt;
			cfg_dec.len_pkg     <= len_head + load_dflt + len_check;
			cfg_dec.mode        <= mode_small;
			cfg_dec.tbit_frq    <= 16'd2000;
			cfg_dec.tbit_period <= 20'd50;
		end else begin
			cfg_dec.len_load <= load_next;
			cfg_dec.len_pkg  <= len_head + load_next + len_check;
			if (cfg_numdev >= 8'd16)
				cfg_dec.mode <= mode_large;
			else if (cfg_numdev >= 8'd8)
				cfg_dec.mode <= mode_mid;
			else
				cfg_dec.mode <= mode_small;
			// second stage follows the mode register
			cfg_dec.tbit_frq    <= frq_next;
			cfg_dec.tbit_period <= period_next;
		end
	end

	// the period table must agree with the frequency tables
	a_period_frq: assert property (@(posedge clk_sys) disable iff (rst)
		int'(cfg_dec.tbit_period) * int'(cfg_dec.tbit_frq) == 100000)
		else $error("tbit_period does not match 100000 / tbit_frq");

endmodule

`default_nettype wire

//--- sample_ticker.sv
// sample producer: counts tick periods while running and pushes the current ADC word
`timescale 1ns/10ps
`default_nettype none

module sample_ticker import fetch_pkg::*; (
	input  wire          clk_sys,
	input  wire          rst,
	input  wire          run,
	input  wire period_t tbit_period,
	input  wire sample_t adc_data,
	output logic         push,
	output sample_t      push_data
);

	period_t cnt;
	period_t last;
	logic    tick;

	// terminal count, one push every tbit_period cycles
	assign last = tbit_period - 20'd1;
	assign tick = run && (cnt >= last);

	// ----------------------------------------------------------------------
	// period counter
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cnt  <= '0;
			push <= 1'b0;
		end else if (!run) begin
			// held at zero while stopped
			cnt  <= '0;
			push <= 1'b0;
		end else if (tick) begin
			cnt  <= '0;
			push <= 1'b1;
		end else begin
			cnt  <= cnt + 20'd1;
			push <= 1'b0;
		end
	end

	// capture on terminal count
	always_ff @(posedge clk_sys) begin
		if (tick)
			push_data <= adc_data;
	end

endmodule

`default_nettype wire

//--- sample_fifo.sv
// sample buffer: synchronous FIFO with occupancy count and sticky overflow flag
`timescale 1ns/10ps
`default_nettype none

module sample_fifo import fetch_pkg::*; #(
	parameter int fifo_depth_log2 = 8
) (
	input  wire                         clk_sys,
	input  wire                         rst,
	input  wire                         push,
	input  wire sample_t                push_data,
	input  wire                         pop,
	output sample_t                     pop_data,
	output logic [fifo_depth_log2:0]    count,
	output logic                        overflow
);

	localparam int depth = 1 << fifo_depth_log2;

	sample_t                     mem [depth];
	logic [fifo_depth_log2-1:0]  wr_ptr;
	logic [fifo_depth_log2-1:0]  rd_ptr;
	logic                        full;
	logic                        wr_en;

	// msb of the count only sets when every slot is used
	assign full  = count[fifo_depth_log2];
	assign wr_en = push && !full;

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (wr_en)
			mem[wr_ptr] <= push_data;
		// read word shows up the cycle after pop
		if (pop)
			pop_data <= mem[rd_ptr];
	end

	// ----------------------------------------------------------------------
	// pointers, count, overflow
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// dropped word, stays set until reset
			if (push && full)
				overflow <= 1'b1;
		end
	end

	// the framer must only pop what is there
	a_no_pop_empty: assert property (@(posedge clk_sys) disable iff (rst) pop |-> count != '0)
		else $error("pop issued on empty FIFO");

endmodule

`default_nettype wire

//--- packet_framer.sv
// packet framer that wraps buffered samples in header and check words
`timescale 1ns/10ps
`default_nettype none

module packet_framer import fetch_pkg::*; #(
	parameter int fifo_depth_log2 = 8
) (
	input  wire                          clk_sys,
	input  wire                          rst,
	input  wire                          run,
	input  wire cfg_dec_t                cfg_dec,
	input  wire  [7:0]                   cfg_numdev,
	input  wire  [fifo_depth_log2:0]     count,
	output logic                         pop,
	input  wire sample_t                 pop_data,
	output word_t                        out_word,
	output logic                         out_valid,
	output logic                         out_sop,
	output logic                         out_eop
);

	frame_state_t state;
	len_t         word_cnt;
	len_t         pop_cnt;
	logic         pop_q;
	word_t        sum;
	word_t        seq;
	word_t        head_word;

	// pop while samples are buffered and the payload is not complete
	assign pop = (state == load) && (count != '0) && (pop_cnt < cfg_dec.len_load);

	// ----------------------------------------------------------------------
	// header word select
	// ----------------------------------------------------------------------
	always_comb begin
		case (word_cnt)
			16'd0:   head_word = sync_word;
			16'd1:   head_word = cfg_dec.len_pkg;
			16'd2:   head_word = seq;
			16'd3:   head_word = cfg_dec.tbit_frq;
			16'd4:   head_word = {cfg_dec.mode, 6'b0, cfg_numdev};
			default: head_word = '0;
		endcase
	end

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state    <= idle;
			word_cnt <= '0;
			pop_cnt  <= '0;
			pop_q    <= 1'b0;
			sum      <= '0;
			seq      <= '0;
		end else begin
			pop_q <= pop;
			case (state)
				idle: begin
					if (run) begin
						state    <= head;
						word_cnt <= '0;
					end
				end
				head: begin
					if (word_cnt == len_head - 16'd1) begin
						state    <= load;
						word_cnt <= '0;
						pop_cnt  <= '0;
						sum      <= '0;
					end else begin
						word_cnt <= word_cnt + 16'd1;
					end
				end
				load: begin
					if (pop)
						pop_cnt <= pop_cnt + 16'd1;
					// word_cnt counts payload words already presented
					if (pop_q) begin
						sum      <= sum + pop_data;
						word_cnt <= word_cnt + 16'd1;
						if (word_cnt == cfg_dec.len_load - 16'd1)
							state <= check0;
					end
				end
				check0: state <= check1;
				check1: begin
					seq      <= seq + 16'd1;
					word_cnt <= '0;
					state    <= run ? head : idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// output mux
	// ----------------------------------------------------------------------
	always_comb begin
		out_word  = '0;
		out_valid = 1'b0;
		out_sop   = 1'b0;
		out_eop   = 1'b0;
		case (state)
			head: begin
				out_word  = head_word;
				out_valid = 1'b1;
				out_sop   = (word_cnt == '0);
			end
			load: begin
				out_word  = pop_data;
				out_valid = pop_q;
			end
			check0: begin
				out_word  = sum;
				out_valid = 1'b1;
			end
			check1: begin
				out_word  = ~sum;
				out_valid = 1'b1;
				out_eop   = 1'b1;
			end
			default: ;
		endcase
	end

	// configuration must hold still while a packet is being built
	a_cfg_stable: assert property (@(posedge clk_sys) disable iff (rst)
		(state != idle) |=> $stable(cfg_dec))
		else $error("decoded configuration changed during a packet");

endmodule

`default_nettype wire

//--- fetch_top.sv
// sampling front end top: decoder, tick producer, sample FIFO and packet framer
`timescale 1ns/10ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
	parameter int samples_per_unit = 900,
	parameter int fifo_depth_log2  = 8
) (
	input  wire          clk_sys,
	input  wire          rst,
	input  wire          run,
	input  wire  [7:0]   cfg_numdev,
	input  wire  [7:0]   cfg_sample,
	input  wire sample_t adc_data,
	output word_t        out_word,
	output logic         out_valid,
	output logic         out_sop,
	output logic         out_eop,
	output logic         overflow,
	output cfg_dec_t     cfg_dec
);

	// ----------------------------------------------------------------------
	// internal links
	// ----------------------------------------------------------------------
	logic                     push;
	sample_t                  push_data;
	logic                     pop;
	sample_t                  pop_data;
	logic [fifo_depth_log2:0] count;

	fetch_base #(
		.samples_per_unit(samples_per_unit)
	) base_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.cfg_numdev(cfg_numdev),
		.cfg_sample(cfg_sample),
		.cfg_dec   (cfg_dec)
	);

	sample_ticker ticker_i (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.run        (run),
		.tbit_period(cfg_dec.tbit_period),
		.adc_data   (adc_data),
		.push       (push),
		.push_data  (push_data)
	);

	// absorbs the gap between tick rate and output rate
	sample_fifo #(
		.fifo_depth_log2(fifo_depth_log2)
	) fifo_i (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.push     (push),
		.push_data(push_data),
		.pop      (pop),
		.pop_data (pop_data),
		.count    (count),
		.overflow (overflow)
	);

	packet_framer #(
		.fifo_depth_log2(fifo_depth_log2)
	) framer_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.run       (run),
		.cfg_dec   (cfg_dec),
		.cfg_numdev(cfg_numdev),
		.count     (count),
		.pop       (pop),
		.pop_data  (pop_data),
		.out_word  (out_word),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop)
	);

endmodule

`default_nettype wire

//--- tb_fetch_top.sv
// testbench for the sampling front end checking decoder, header, payload and check words
`timescale 1ns/10ps
`default_nettype none

module tb_fetch_top import fetch_pkg::*; ();

	localparam int clk_period = 40;

	// one line of the golden file
	typedef struct packed {
		logic [7:0] numdev;
		logic [7:0] sample;
		sample_t    adc;
		len_t       len_pkg;
		frq_t       frq;
		period_t    period;
		word_t      checksum;
	} golden_case_t;

	logic         clk_sys;
	logic         rst;
	logic         run;
	logic [7:0]   cfg_numdev;
	logic [7:0]   cfg_sample;
	sample_t      adc_data;
	word_t        out_word;
	logic         out_valid;
	logic         out_sop;
	logic         out_eop;
	logic         overflow;
	cfg_dec_t     cfg_dec;

	golden_case_t cases[$];
	int           errors;
	int           checks;
	int           limit_cycles;
	logic         load_done;

	fetch_top #(
		.samples_per_unit(9),
		.fifo_depth_log2 (8)
	) dut_i (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.run       (run),
		.cfg_numdev(cfg_numdev),
		.cfg_sample(cfg_sample),
		.adc_data  (adc_data),
		.out_word  (out_word),
		.out_valid (out_valid),
		.out_sop   (out_sop),
		.out_eop   (out_eop),
		.overflow  (overflow),
		.cfg_dec   (cfg_dec)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_len(input string name, input len_t got, input len_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_frq(input string name, input frq_t got, input frq_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_period(input string name, input period_t got, input period_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_mode(input string name, input mode_t got, input mode_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// device-count groups are below 8, 8 to 15, and 16 and up
	function automatic mode_t expected_mode(input logic [7:0] numdev);
		if (numdev >= 8'd16)
			return 2'h3;
		else if (numdev >= 8'd8)
			return 2'h1;
		return 2'h0;
	endfunction

	task automatic print_summary();
		$display("%0d cases, %0d checks, %0d errors", cases.size(), checks, errors);
	endtask

	// ----------------------------------------------------------------------
	// golden file
	// ----------------------------------------------------------------------
	task automatic read_golden_file();
		int           fd;
		int           n;
		int           f_numdev;
		int           f_sample;
		int           f_adc;
		int           f_len;
		int           f_frq;
		int           f_period;
		int           f_sum;
		string        line;
		golden_case_t gc;
		fd = $fopen("fetch_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open fetch_golden.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %h %d %d %d %h", f_numdev, f_sample, f_adc,
					f_len, f_frq, f_period, f_sum);
				if (n == 7) begin
					gc.numdev   = f_numdev[7:0];
					gc.sample   = f_sample[7:0];
					gc.adc      = f_adc[15:0];
					gc.len_pkg  = f_len[15:0];
					gc.frq      = f_frq[15:0];
					gc.period   = f_period[19:0];
					gc.checksum = f_sum[15:0];
					cases.push_back(gc);
				end
			end
		end
		$fclose(fd);
		if (cases.size() == 0) begin
			errors++;
			$display("no test cases found in fetch_golden.txt");
		end
	endtask

	// ----------------------------------------------------------------------
	// packet capture and checks
	// ----------------------------------------------------------------------
	task automatic receive_packet(input golden_case_t gc, input word_t exp_seq);
		word_t words[$];
		logic  sops[$];
		logic  eop_seen;
		int    idx;
		len_t  load_len;
		eop_seen  = 1'b0;
		load_len  = gc.len_pkg - len_head - len_check;
		// outputs settle after the rising edge so they are sampled on the falling one
		while (!eop_seen) begin
			@(negedge clk_sys);
			if (out_valid) begin
				words.push_back(out_word);
				sops.push_back(out_sop);
				eop_seen = out_eop;
			end
		end
		check_len("packet length", len_t'(words.size()), gc.len_pkg);
		if (words.size() != int'(gc.len_pkg))
			return;
		check_flag("out_sop on first word", sops[0], 1'b1);
		for (idx = 1; idx < words.size(); idx++)
			check_flag($sformatf("out_sop on word %0d", idx), sops[idx], 1'b0);
		check_word("out_word sync", words[0], sync_word);
		check_word("out_word len_pkg", words[1], gc.len_pkg);
		check_word("out_word sequence", words[2], exp_seq);
		check_word("out_word tbit_frq", words[3], gc.frq);
		check_word("out_word mode and devices", words[4],
			{expected_mode(gc.numdev), 6'b0, gc.numdev});
		for (idx = 5; idx < int'(len_head); idx++)
			check_word($sformatf("out_word header %0d", idx), words[idx], '0);
		for (idx = int'(len_head); idx < int'(len_head + load_len); idx++)
			check_word($sformatf("out_word payload %0d", idx), words[idx], gc.adc);
		check_word("out_word check0", words[words.size() - 2], gc.checksum);
		check_word("out_word check1", words[words.size() - 1], ~gc.checksum);
	endtask

	task automatic run_case(input golden_case_t gc);
		@(negedge clk_sys);
		rst        = 1'b1;
		run        = 1'b0;
		cfg_numdev = gc.numdev;
		cfg_sample = gc.sample;
		adc_data   = gc.adc;
		repeat (2) @(negedge clk_sys);
		rst = 1'b0;
		// decoder needs three cycles to settle
		repeat (3) @(negedge clk_sys);
		check_len("cfg_dec.len_pkg", cfg_dec.len_pkg, gc.len_pkg);
		check_len("cfg_dec.len_load", cfg_dec.len_load, gc.len_pkg - len_head - len_check);
		check_mode("cfg_dec.mode", cfg_dec.mode, expected_mode(gc.numdev));
		check_frq("cfg_dec.tbit_frq", cfg_dec.tbit_frq, gc.frq);
		check_period("cfg_dec.tbit_period", cfg_dec.tbit_period, gc.period);
		// two packets back to back before stopping on the last check word
		run = 1'b1;
		receive_packet(gc, 16'd0);
		receive_packet(gc, 16'd1);
		run = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_flag("overflow", overflow, 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------------------
	initial begin
		rst          = 1'b1;
		run          = 1'b0;
		cfg_numdev   = '0;
		cfg_sample   = '0;
		adc_data     = '0;
		errors       = 0;
		checks       = 0;
		load_done    = 1'b0;
		limit_cycles = 50;
		read_golden_file();
		foreach (cases[i])
			limit_cycles += int'(cases[i].len_pkg) * int'(cases[i].period) * 2 + 100;
		load_done = 1'b1;
		repeat (2) @(negedge clk_sys);
		rst = 1'b0;
		foreach (cases[i])
			run_case(cases[i]);
		print_summary();
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		wait (load_done);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("timeout: run did not finish within %0d clock cycles", limit_cycles);
		print_summary();
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_golden.txt
# numdev sample adc(hex) len_pkg tbit_frq tbit_period checksum(hex)
# decimal columns except adc and checksum; checksum is the payload sum mod 2^16
1 20 1234 194 2000 50 cc90
3 10 0101 104 1000 100 5a5a
5 5 00ff 59 500 200 2cd3
7 2 ffff 32 200 500 ffee
0 1 8000 23 200 500 8000
4 7 0001 194 2000 50 00b4
8 20 0100 194 4000 25 b400
9 10 0010 104 2000 50 05a0
10 5 1000 59 1000 100 d000
12 2 0abc 32 500 200 c138
14 1 7fff 23 200 500 7ff7
15 0 0002 194 4000 25 0168
16 20 0003 194 5000 20 021c
20 10 0200 104 4000 25 b400
32 5 0005 59 2000 50 00e1
64 2 0100 32 1000 100 1200
128 1 a5a5 23 500 200 d2cd
255 255 0004 194 5000 20 02d0

//--- files.f
fetch_pkg.sv
fetch_base.sv
sample_ticker.sv
sample_fifo.sv
packet_framer.sv
fetch_top.sv
tb_fetch_top.sv

//--- Makefile
# Verilator build and run for the sampling front end

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
